/* Makefile */
SIM   := verilator
TOP   := tb_mcu_ao
FLIST := list.f
FLAGS := --binary --timing --assert -Wno-fatal

BIN   := obj_dir/V$(TOP)
SRCS  := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

# Passes only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf obj_dir

/* list.f */
logic/mcu_ao_pkg.sv
logic/ao_bus_ctrl.sv
logic/gpio_bank.sv
logic/clint_lite.sv
logic/irq_ctrl.sv
logic/mcu_ao_top.sv
test/tb_mcu_ao.sv

/* logic/ao_bus_ctrl.sv */
// ==============================
// Wishbone classic slave with region
// decode, read mux and exit register
// ==============================
`timescale 1ns/100ps
`default_nettype none

module ao_bus_ctrl (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  mcu_ao_pkg::wb_req_t           wb_req_i,
  output mcu_ao_pkg::wb_rsp_t           wb_rsp_o,
  output mcu_ao_pkg::reg_req_t          ao_gpio_req_o,
  output mcu_ao_pkg::reg_req_t          gpio_req_o,
  output mcu_ao_pkg::reg_req_t          clint_req_o,
  output mcu_ao_pkg::reg_req_t          irq_req_o,
  input  logic [mcu_ao_pkg::DATA_W-1:0] ao_gpio_rdata_i,
  input  logic [mcu_ao_pkg::DATA_W-1:0] gpio_rdata_i,
  input  logic [mcu_ao_pkg::DATA_W-1:0] clint_rdata_i,
  input  logic [mcu_ao_pkg::DATA_W-1:0] irq_rdata_i,
  output logic                          exit_valid_o,
  output logic [mcu_ao_pkg::DATA_W-1:0] exit_value_o
);
  import mcu_ao_pkg::*;

  logic                 access;
  logic [REGION_W-1:0]  region;
  logic [REG_OFF_W-1:0] offset;
  logic [DATA_W-1:0]    wdata;
  logic [DATA_W-1:0]    rdata_mux;
  reg_req_t             base_req;
  logic                 exit_wr;
  logic                 ack_q;
  logic [DATA_W-1:0]    rdata_q;
  logic                 exit_arm_q;
  logic                 exit_valid_q;
  logic [DATA_W-1:0]    exit_value_q;

  // New access when strobed and no ack outstanding
  assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
  assign region = wb_req_i.adr[ADDR_W-1:REG_OFF_W];
  assign offset = wb_req_i.adr[REG_OFF_W-1:0];

  // Bytes without sel are written as zero
  always_comb begin
    for (int b = 0; b < DATA_W / 8; b++) begin
      wdata[8*b +: 8] = wb_req_i.sel[b] ? wb_req_i.dat[8*b +: 8] : 8'h00;
    end
  end

  assign base_req = '{valid: 1'b0, we: wb_req_i.we, offset: offset, wdata: wdata};

  always_comb begin
    ao_gpio_req_o       = base_req;
    gpio_req_o          = base_req;
    clint_req_o         = base_req;
    irq_req_o           = base_req;
    ao_gpio_req_o.valid = access && (region == REGION_AO_GPIO);
    gpio_req_o.valid    = access && (region == REGION_GPIO);
    clint_req_o.valid   = access && (region == REGION_CLINT);
    irq_req_o.valid     = access && (region == REGION_IRQ);
  end

  assign exit_wr = access && wb_req_i.we && (region == REGION_SOC) && (offset == SOC_EXIT);

  always_comb begin
    case (region)
      REGION_SOC:     rdata_mux = (offset == SOC_EXIT) ? exit_value_q : '0;
      REGION_AO_GPIO: rdata_mux = ao_gpio_rdata_i;
      REGION_GPIO:    rdata_mux = gpio_rdata_i;
      REGION_CLINT:   rdata_mux = clint_rdata_i;
      REGION_IRQ:     rdata_mux = irq_rdata_i;
      default:        rdata_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q        <= 1'b0;
      exit_arm_q   <= 1'b0;
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else begin
      ack_q      <= access;
      exit_arm_q <= exit_wr;
      if (exit_wr) begin
        exit_value_q <= wdata;
      end
      // Valid follows the ack cycle and then stays
      if (exit_arm_q) begin
        exit_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= wb_req_i.we ? '0 : rdata_mux;
    end
  end

  assign wb_rsp_o.dat  = rdata_q;
  assign wb_rsp_o.ack  = ack_q;
  assign exit_valid_o  = exit_valid_q;
  assign exit_value_o  = exit_value_q;

  // Exactly one wait cycle, then a single ack
  a_ack_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    access |=> ack_q ##1 !ack_q);

endmodule

`default_nettype wire

/* logic/clint_lite.sv */
// ==============================
// Timer and software interrupt:
// mtime, mtimecmp and msip
// ==============================
`timescale 1ns/100ps
`default_nettype none

module clint_lite (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  mcu_ao_pkg::reg_req_t          req_i,
  output logic [mcu_ao_pkg::DATA_W-1:0] rdata_o,
  output logic                          timer_irq_o,
  output logic                          sw_irq_o
);
  import mcu_ao_pkg::*;

  logic              wr;
  logic [DATA_W-1:0] mtime_q;
  logic [DATA_W-1:0] mtimecmp_q;
  logic              msip_q;

  assign wr = req_i.valid && req_i.we;

  // mtime is free running and not writable
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      mtime_q <= mtime_q + 1'b1;
      if (wr) begin
        case (req_i.offset)
          CLINT_MTIMECMP: mtimecmp_q <= req_i.wdata;
          CLINT_MSIP:     msip_q     <= req_i.wdata[0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (req_i.offset)
      CLINT_MTIME:    rdata_o = mtime_q;
      CLINT_MTIMECMP: rdata_o = mtimecmp_q;
      CLINT_MSIP:     rdata_o = {{(DATA_W-1){1'b0}}, msip_q};
      default:        rdata_o = '0;
    endcase
  end

  // Level, cleared by moving mtimecmp up
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign sw_irq_o    = msip_q;

endmodule

`default_nettype wire

/* logic/gpio_bank.sv */
// ==============================
// GPIO bank: out, oe, input sync
// and rising-edge events
// ==============================
`timescale 1ns/100ps
`default_nettype none

module gpio_bank #(
  parameter int unsigned NUM_PINS = mcu_ao_pkg::NUM_AO_GPIO
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  mcu_ao_pkg::reg_req_t          req_i,
  output logic [mcu_ao_pkg::DATA_W-1:0] rdata_o,
  input  logic [NUM_PINS-1:0]           pins_i,
  // Row 1 is out, row 0 is output enable
  output logic [1:0][NUM_PINS-1:0]      pads_o,
  output logic [NUM_PINS-1:0]           event_o
);
  import mcu_ao_pkg::*;

  logic                wr;
  logic [NUM_PINS-1:0] out_q;
  logic [NUM_PINS-1:0] oe_q;
  logic [NUM_PINS-1:0] rise_en_q;
  logic [NUM_PINS-1:0] sync_q;
  logic [NUM_PINS-1:0] in_q;
  logic [NUM_PINS-1:0] in_prev_q;
  logic [NUM_PINS-1:0] event_q;

  assign wr = req_i.valid && req_i.we;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      rise_en_q <= '0;
    end else if (wr) begin
      case (req_i.offset)
        GPIO_OUT:     out_q     <= req_i.wdata[NUM_PINS-1:0];
        GPIO_OE:      oe_q      <= req_i.wdata[NUM_PINS-1:0];
        GPIO_RISE_EN: rise_en_q <= req_i.wdata[NUM_PINS-1:0];
        default: ;
      endcase
    end
  end

  // Two flop synchronizer, then edge detect
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q    <= '0;
      in_q      <= '0;
      in_prev_q <= '0;
      event_q   <= '0;
    end else begin
      sync_q    <= pins_i;
      in_q      <= sync_q;
      in_prev_q <= in_q;
      event_q   <= in_q & ~in_prev_q & rise_en_q;
    end
  end

  always_comb begin
    case (req_i.offset)
      GPIO_OUT:     rdata_o = DATA_W'(out_q);
      GPIO_OE:      rdata_o = DATA_W'(oe_q);
      GPIO_IN:      rdata_o = DATA_W'(in_q);
      GPIO_RISE_EN: rdata_o = DATA_W'(rise_en_q);
      default:      rdata_o = '0;
    endcase
  end

  assign pads_o[1] = out_q;
  assign pads_o[0] = oe_q;
  assign event_o   = event_q;

  // An event needs its enable in the cycle it was detected
  a_event_enabled: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (event_o & ~$past(rise_en_q)) == '0);

endmodule

`default_nettype wire

/* logic/irq_ctrl.sv */
// ==============================
// Interrupt word, pending latch,
// enable mask and priority id
// ==============================
`timescale 1ns/100ps
`default_nettype none

module irq_ctrl (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  mcu_ao_pkg::reg_req_t               req_i,
  output logic [mcu_ao_pkg::DATA_W-1:0]      rdata_o,
  input  logic [mcu_ao_pkg::NUM_AO_GPIO-1:0] ao_event_i,
  input  logic                               ext_event_i,
  input  logic                               timer_irq_i,
  input  logic                               sw_irq_i,
  output logic                               irq_o,
  output logic [4:0]                         irq_id_o,
  input  logic                               irq_ack_i
);
  import mcu_ao_pkg::*;

  localparam int unsigned AO_ID_LSB = IRQ_ID_FAST_BASE + AO_GPIO_FAST_LSB;

  logic [DATA_W-1:0]      enable_q;
  logic [NUM_AO_GPIO-1:0] ao_pend_q;
  logic                   ext_pend_q;
  irq_word_u              pend_word;
  irq_word_u              irq_word;
  logic [DATA_W-1:0]      masked;
  logic                   ack_ok;
  logic [DATA_W-1:0]      clr_word;

  // Latched sources first, level sources on top
  always_comb begin
    pend_word.raw = '0;
    pend_word.f.fast[AO_GPIO_FAST_LSB +: NUM_AO_GPIO] = ao_pend_q;
    pend_word.f.external = ext_pend_q;
    irq_word            = pend_word;
    irq_word.f.timer    = timer_irq_i;
    irq_word.f.software = sw_irq_i;
  end

  assign masked = irq_word.raw & enable_q;
  assign irq_o  = |masked;

  // Highest set bit wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < DATA_W; i++) begin
      if (masked[i]) begin
        irq_id_o = 5'(i);
      end
    end
  end

  assign ack_ok   = irq_ack_i && irq_o;
  assign clr_word = ack_ok ? (DATA_W'(1) << irq_id_o) : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q   <= '0;
      ao_pend_q  <= '0;
      ext_pend_q <= 1'b0;
    end else begin
      if (req_i.valid && req_i.we && (req_i.offset == IRQ_ENABLE)) begin
        enable_q <= req_i.wdata;
      end
      // Set wins over clear
      ao_pend_q  <= (ao_pend_q & ~clr_word[AO_ID_LSB +: NUM_AO_GPIO]) | ao_event_i;
      ext_pend_q <= (ext_pend_q & ~clr_word[IRQ_ID_EXTERNAL]) | ext_event_i;
    end
  end

  always_comb begin
    case (req_i.offset)
      IRQ_WORD:    rdata_o = irq_word.raw;
      IRQ_ENABLE:  rdata_o = enable_q;
      IRQ_PENDING: rdata_o = pend_word.raw;
      default:     rdata_o = '0;
    endcase
  end

  // A stray ack with nothing enabled leaves pending untouched
  a_ack_ignored: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (irq_ack_i && !irq_o) |=>
      (ao_pend_q == $past(ao_pend_q | ao_event_i)) &&
      (ext_pend_q == $past(ext_pend_q | ext_event_i)));

endmodule

`default_nettype wire

/* logic/mcu_ao_pkg.sv */
// ==============================
// Always-on package: widths, address map,
// bus structs and interrupt word union
// ==============================
`default_nettype none

package mcu_ao_pkg;

  localparam int unsigned NUM_GPIO    = 32;
  localparam int unsigned NUM_AO_GPIO = 8;
  localparam int unsigned ADDR_W      = 12;
  localparam int unsigned DATA_W      = 32;
  localparam int unsigned REG_OFF_W   = 8;
  localparam int unsigned REGION_W    = ADDR_W - REG_OFF_W;

  // Region codes on adr[11:8]
  localparam logic [REGION_W-1:0] REGION_SOC     = 4'd0;
  localparam logic [REGION_W-1:0] REGION_AO_GPIO = 4'd1;
  localparam logic [REGION_W-1:0] REGION_GPIO    = 4'd2;
  localparam logic [REGION_W-1:0] REGION_CLINT   = 4'd3;
  localparam logic [REGION_W-1:0] REGION_IRQ     = 4'd4;

  localparam logic [REG_OFF_W-1:0] GPIO_OUT     = 8'h00;
  localparam logic [REG_OFF_W-1:0] GPIO_OE      = 8'h04;
  localparam logic [REG_OFF_W-1:0] GPIO_IN      = 8'h08;
  localparam logic [REG_OFF_W-1:0] GPIO_RISE_EN = 8'h0C;

  localparam logic [REG_OFF_W-1:0] CLINT_MTIME    = 8'h00;
  localparam logic [REG_OFF_W-1:0] CLINT_MTIMECMP = 8'h04;
  localparam logic [REG_OFF_W-1:0] CLINT_MSIP     = 8'h08;

  localparam logic [REG_OFF_W-1:0] IRQ_WORD    = 8'h00;
  localparam logic [REG_OFF_W-1:0] IRQ_ENABLE  = 8'h04;
  localparam logic [REG_OFF_W-1:0] IRQ_PENDING = 8'h08;

  localparam logic [REG_OFF_W-1:0] SOC_EXIT = 8'h00;

  localparam int unsigned IRQ_ID_SOFTWARE  = 3;
  localparam int unsigned IRQ_ID_TIMER     = 7;
  localparam int unsigned IRQ_ID_EXTERNAL  = 11;
  localparam int unsigned IRQ_ID_FAST_BASE = 16;
  // AO pin n lands on id 22+n
  localparam int unsigned AO_GPIO_FAST_LSB = 6;

  typedef struct packed {
    logic [ADDR_W-1:0]   adr;
    logic [DATA_W-1:0]   dat;
    logic                we;
    logic [DATA_W/8-1:0] sel;
    logic                cyc;
    logic                stb;
  } wb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] dat;
    logic              ack;
  } wb_rsp_t;

  typedef struct packed {
    logic                 valid;
    logic                 we;
    logic [REG_OFF_W-1:0] offset;
    logic [DATA_W-1:0]    wdata;
  } reg_req_t;

  typedef struct packed {
    logic [NUM_GPIO-1:0] out;
    logic [NUM_GPIO-1:0] oe;
  } pad_out_t;

  typedef struct packed {
    logic        reserved;
    logic [14:0] fast;
    logic [3:0]  zero_15_12;
    logic        external;
    logic [2:0]  zero_10_8;
    logic        timer;
    logic [2:0]  zero_6_4;
    logic        software;
    logic [2:0]  zero_2_0;
  } irq_fields_t;

  typedef union packed {
    logic [31:0] raw;
    irq_fields_t f;
  } irq_word_u;

endpackage

`default_nettype wire

/* logic/mcu_ao_top.sv */
// ==============================
// Always-on top: bus slave, two GPIO
// banks, timer and interrupt control
// ==============================
`timescale 1ns/100ps
`default_nettype none

module mcu_ao_top (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  mcu_ao_pkg::wb_req_t             wb_req_i,
  output mcu_ao_pkg::wb_rsp_t             wb_rsp_o,
  input  logic [mcu_ao_pkg::NUM_GPIO-1:0] gpio_i,
  output mcu_ao_pkg::pad_out_t            gpio_o,
  output logic                            irq_o,
  output logic [4:0]                      irq_id_o,
  input  logic                            irq_ack_i,
  output logic                            exit_valid_o,
  output logic [mcu_ao_pkg::DATA_W-1:0]   exit_value_o
);
  import mcu_ao_pkg::*;

  localparam int unsigned NUM_MAIN_GPIO = NUM_GPIO - NUM_AO_GPIO;

  reg_req_t                      ao_gpio_req;
  reg_req_t                      gpio_req;
  reg_req_t                      clint_req;
  reg_req_t                      irq_req;
  logic [DATA_W-1:0]             ao_gpio_rdata;
  logic [DATA_W-1:0]             gpio_rdata;
  logic [DATA_W-1:0]             clint_rdata;
  logic [DATA_W-1:0]             irq_rdata;
  logic [1:0][NUM_AO_GPIO-1:0]   ao_pads;
  logic [1:0][NUM_MAIN_GPIO-1:0] main_pads;
  logic [NUM_AO_GPIO-1:0]        ao_event;
  logic [NUM_MAIN_GPIO-1:0]      main_event;
  logic                          ext_event;
  logic                          timer_irq;
  logic                          sw_irq;

  ao_bus_ctrl ao_bus_ctrl0 (
    .clk_i,
    .arst_n_i,
    .wb_req_i,
    .wb_rsp_o,
    .ao_gpio_req_o  (ao_gpio_req),
    .gpio_req_o     (gpio_req),
    .clint_req_o    (clint_req),
    .irq_req_o      (irq_req),
    .ao_gpio_rdata_i(ao_gpio_rdata),
    .gpio_rdata_i   (gpio_rdata),
    .clint_rdata_i  (clint_rdata),
    .irq_rdata_i    (irq_rdata),
    .exit_valid_o,
    .exit_value_o
  );

  // Pins 0 to 7
  gpio_bank #(
    .NUM_PINS(NUM_AO_GPIO)
  ) ao_gpio_bank0 (
    .clk_i,
    .arst_n_i,
    .req_i  (ao_gpio_req),
    .rdata_o(ao_gpio_rdata),
    .pins_i (gpio_i[NUM_AO_GPIO-1:0]),
    .pads_o (ao_pads),
    .event_o(ao_event)
  );

  // Pins 8 to 31
  gpio_bank #(
    .NUM_PINS(NUM_MAIN_GPIO)
  ) gpio_bank0 (
    .clk_i,
    .arst_n_i,
    .req_i  (gpio_req),
    .rdata_o(gpio_rdata),
    .pins_i (gpio_i[NUM_GPIO-1:NUM_AO_GPIO]),
    .pads_o (main_pads),
    .event_o(main_event)
  );

  clint_lite clint_lite0 (
    .clk_i,
    .arst_n_i,
    .req_i      (clint_req),
    .rdata_o    (clint_rdata),
    .timer_irq_o(timer_irq),
    .sw_irq_o   (sw_irq)
  );

  irq_ctrl irq_ctrl0 (
    .clk_i,
    .arst_n_i,
    .req_i      (irq_req),
    .rdata_o    (irq_rdata),
    .ao_event_i (ao_event),
    .ext_event_i(ext_event),
    .timer_irq_i(timer_irq),
    .sw_irq_i   (sw_irq),
    .irq_o,
    .irq_id_o,
    .irq_ack_i
  );

  // Main bank events share the external line
  assign ext_event  = |main_event;
  assign gpio_o.out = {main_pads[1], ao_pads[1]};
  assign gpio_o.oe  = {main_pads[0], ao_pads[0]};

endmodule

`default_nettype wire

/* test/tb_mcu_ao.sv */
// ==============================
// Testbench for the always-on top:
// bus and core tasks, model and checks
// ==============================
`timescale 1ns/100ps
`default_nettype none

module tb_mcu_ao;
  import mcu_ao_pkg::*;

  localparam int unsigned WAIT_LIMIT = 200;
  localparam logic [31:0] SEED       = 32'h9095_f4c4;

  logic              clk;
  logic              arst_n;
  wb_req_t           wb_req;
  wb_rsp_t           wb_rsp;
  logic [NUM_GPIO-1:0] gpio_in;
  pad_out_t          gpio_pads;
  logic              irq;
  logic [4:0]        irq_id;
  logic              irq_ack;
  logic              exit_valid;
  logic [DATA_W-1:0] exit_value;

  int unsigned n_tests;
  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned test_errors;

  mcu_ao_top dut0 (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .wb_req_i    (wb_req),
    .wb_rsp_o    (wb_rsp),
    .gpio_i      (gpio_in),
    .gpio_o      (gpio_pads),
    .irq_o       (irq),
    .irq_id_o    (irq_id),
    .irq_ack_i   (irq_ack),
    .exit_valid_o(exit_valid),
    .exit_value_o(exit_value)
  );

  always #4 clk = ~clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      test_errors++;
      $display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout: no %s after %0d cycles", what, WAIT_LIMIT);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("%s: %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  task automatic cycles(input int unsigned n);
    repeat (n) @(negedge clk);
  endtask

  // Classic cycle, held until ack and dropped right after it
  task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    int unsigned n;
    @(negedge clk);
    wb_req.adr = adr;
    wb_req.dat = wdata;
    wb_req.we  = we;
    wb_req.sel = '1;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    n = 0;
    @(negedge clk);
    while (!wb_rsp.ack && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    rdata      = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    if (!wb_rsp.ack) begin
      abort_run("wishbone ack");
    end
  endtask

  task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] unused;
    bus_access(1'b1, adr, wdata, unused);
  endtask

  task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] rdata);
    bus_access(1'b0, adr, '0, rdata);
  endtask

  task automatic wait_irq(input logic level, input string what);
    int unsigned n;
    n = 0;
    while (irq !== level && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (irq !== level) begin
      abort_run(what);
    end
  endtask

  // Core side takes the interrupt
  task automatic pulse_ack();
    @(negedge clk);
    irq_ack = 1'b1;
    @(negedge clk);
    irq_ack = 1'b0;
  endtask

  task automatic pad_writes();
    logic [DATA_W-1:0] ao_out;
    logic [DATA_W-1:0] ao_oe;
    logic [DATA_W-1:0] main_out;
    logic [DATA_W-1:0] main_oe;
    logic [DATA_W-1:0] rd;
    check("gpio_o.out after reset", gpio_pads.out, '0);
    check("gpio_o.oe after reset", gpio_pads.oe, '0);
    check("irq_o after reset", irq, 0);
    check("exit_valid_o after reset", exit_valid, 0);
    for (int i = 0; i < 8; i++) begin
      ao_out   = $urandom;
      ao_oe    = $urandom;
      main_out = $urandom;
      main_oe  = $urandom;
      wb_write({REGION_AO_GPIO, GPIO_OUT}, ao_out);
      wb_write({REGION_AO_GPIO, GPIO_OE}, ao_oe);
      wb_write({REGION_GPIO, GPIO_OUT}, main_out);
      wb_write({REGION_GPIO, GPIO_OE}, main_oe);
      cycles(1);
      check("gpio_o.out", gpio_pads.out, {main_out[23:0], ao_out[7:0]});
      check("gpio_o.oe", gpio_pads.oe, {main_oe[23:0], ao_oe[7:0]});
    end
    wb_read({REGION_AO_GPIO, GPIO_OUT}, rd);
    check("ao GPIO_OUT", rd, {24'h0, ao_out[7:0]});
    wb_read({REGION_GPIO, GPIO_OE}, rd);
    check("main GPIO_OE", rd, {8'h0, main_oe[23:0]});
    end_test("gpio pads");
  endtask

  task automatic pin_reads();
    logic [DATA_W-1:0] pins;
    logic [DATA_W-1:0] rd;
    pad_out_t          pads_before;
    for (int i = 0; i < 4; i++) begin
      pins = $urandom;
      @(negedge clk);
      gpio_in = pins;
      repeat (3) @(posedge clk);
      wb_read({REGION_AO_GPIO, GPIO_IN}, rd);
      check("ao GPIO_IN", rd, {24'h0, pins[7:0]});
      wb_read({REGION_GPIO, GPIO_IN}, rd);
      check("main GPIO_IN", rd, {8'h0, pins[31:8]});
    end
    // Unmapped regions and offsets
    wb_read({4'h5, 8'h00}, rd);
    check("region 5 read", rd, '0);
    wb_read({4'hF, 8'h04}, rd);
    check("region 15 read", rd, '0);
    wb_read({REGION_AO_GPIO, 8'h10}, rd);
    check("ao gpio offset 0x10 read", rd, '0);
    wb_read({REGION_SOC, 8'h04}, rd);
    check("soc offset 0x04 read", rd, '0);
    pads_before = gpio_pads;
    wb_write({4'h6, GPIO_OUT}, $urandom);
    cycles(1);
    check("gpio_o.out after unmapped write", gpio_pads.out, pads_before.out);
    check("gpio_o.oe after unmapped write", gpio_pads.oe, pads_before.oe);
    gpio_in = '0;
    cycles(4);
    end_test("gpio in");
  endtask

  task automatic fast_irqs();
    int unsigned       pin;
    int unsigned       top;
    int unsigned       n;
    logic [7:0]        mask;
    logic [DATA_W-1:0] rd;
    wb_write({REGION_AO_GPIO, GPIO_RISE_EN}, 32'h0000_00FF);
    wb_write({REGION_IRQ, IRQ_ENABLE}, 32'h3FC0_0000);
    for (int k = 0; k < 4; k++) begin
      pin = $urandom % 8;
      @(negedge clk);
      gpio_in[pin] = 1'b1;
      wait_irq(1'b1, "fast interrupt");
      check("irq_id_o", irq_id, 22 + pin);
      wb_read({REGION_IRQ, IRQ_PENDING}, rd);
      check("IRQ_PENDING", rd, 32'h1 << (22 + pin));
      pulse_ack();
      check("irq_o after ack", irq, 0);
      gpio_in[pin] = 1'b0;
      cycles(4);
    end
    // Several at once, served highest first
    mask = 8'($urandom) | 8'h81;
    @(negedge clk);
    gpio_in[7:0] = mask;
    wait_irq(1'b1, "fast interrupt");
    n = 0;
    while (mask != 0 && n < 16) begin
      top = 0;
      for (int j = 0; j < 8; j++) begin
        if (mask[j]) begin
          top = j;
        end
      end
      check("irq_id_o highest", irq_id, 22 + top);
      pulse_ack();
      mask[top] = 1'b0;
      n++;
    end
    check("irq_o after all acks", irq, 0);
    gpio_in = '0;
    cycles(4);
    end_test("fast irq");
  endtask

  task automatic ext_and_sw_irqs();
    int unsigned pin;
    wb_write({REGION_GPIO, GPIO_RISE_EN}, 32'h00FF_FFFF);
    wb_write({REGION_IRQ, IRQ_ENABLE}, 32'h0000_0808);
    pin = 8 + $urandom % 24;
    @(negedge clk);
    gpio_in[pin] = 1'b1;
    wait_irq(1'b1, "external interrupt");
    check("irq_id_o external", irq_id, IRQ_ID_EXTERNAL);
    wb_write({REGION_CLINT, CLINT_MSIP}, 32'h1);
    check("irq_id_o external over msip", irq_id, IRQ_ID_EXTERNAL);
    pulse_ack();
    check("irq_o with msip", irq, 1);
    check("irq_id_o software", irq_id, IRQ_ID_SOFTWARE);
    wb_write({REGION_CLINT, CLINT_MSIP}, 32'h0);
    check("irq_o after msip clear", irq, 0);
    gpio_in[pin] = 1'b0;
    cycles(4);
    end_test("external and software irq");
  endtask

  task automatic timer_irq_cmp();
    logic [DATA_W-1:0] t0;
    logic [DATA_W-1:0] t1;
    logic [DATA_W-1:0] cmp;
    logic [DATA_W-1:0] rd;
    wb_write({REGION_IRQ, IRQ_ENABLE}, 32'h0000_0080);
    wb_read({REGION_CLINT, CLINT_MTIME}, t0);
    check("irq_o before compare", irq, 0);
    cmp = t0 + 20 + ($urandom % 16);
    wb_write({REGION_CLINT, CLINT_MTIMECMP}, cmp);
    check("irq_o after mtimecmp write", irq, 0);
    wait_irq(1'b1, "timer interrupt");
    check("irq_id_o timer", irq_id, IRQ_ID_TIMER);
    // Only the timer source is active here
    wb_read({REGION_IRQ, IRQ_WORD}, rd);
    check("IRQ_WORD", rd, 32'h1 << IRQ_ID_TIMER);
    wb_read({REGION_CLINT, CLINT_MTIME}, t1);
    check("mtime at or above mtimecmp", t1 >= cmp, 1);
    wb_write({REGION_CLINT, CLINT_MTIMECMP}, t1 + 32'h1000);
    check("irq_o after raising mtimecmp", irq, 0);
    wb_read({REGION_CLINT, CLINT_MTIMECMP}, rd);
    check("CLINT_MTIMECMP", rd, t1 + 32'h1000);
    end_test("timer irq");
  endtask

  task automatic exit_write();
    logic [DATA_W-1:0] val;
    logic [DATA_W-1:0] rd;
    int unsigned       n;
    for (int k = 0; k < 2; k++) begin
      val = $urandom;
      wb_write({REGION_SOC, SOC_EXIT}, val);
      n = 0;
      while (!exit_valid && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
      end
      if (!exit_valid) begin
        abort_run("exit_valid_o");
      end
      check("exit_value_o", exit_value, val);
      wb_read({REGION_SOC, SOC_EXIT}, rd);
      check("SOC_EXIT read", rd, val);
    end
    end_test("exit register");
  endtask

  initial begin
    void'($urandom(SEED));
    clk         = 1'b0;
    arst_n      = 1'b0;
    wb_req      = '0;
    gpio_in     = '0;
    irq_ack     = 1'b0;
    n_tests     = 0;
    n_checks    = 0;
    n_errors    = 0;
    test_errors = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    pad_writes();
    pin_reads();
    fast_irqs();
    ext_and_sw_irqs();
    timer_irq_cmp();
    exit_write();
    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
